// ==== design/replay_trace_pkg.sv ====
package replay_trace_pkg;

    // input word and alignment geometry
    localparam int AXI_WIDTH              = 64;
    localparam int PACKET_ALIGNMENT       = 8;
    localparam int PACKET_ALIGNMENT_WIDTH = 3;
    localparam int AXI_OFFSET_WIDTH       = 6;

    // logging unit geometry
    localparam int LOGGING_UNIT_WIDTH   = 248;
    localparam int OFFSET_WIDTH         = 8;
    localparam int ALIGNED_OFFSET_WIDTH = OFFSET_WIDTH - PACKET_ALIGNMENT_WIDTH;

    // alignment units inside one word, and the index into them
    localparam int AXI_ALIGNED_WIDTH        = AXI_WIDTH / PACKET_ALIGNMENT;
    localparam int AXI_ALIGNED_OFFSET_WIDTH = AXI_OFFSET_WIDTH - PACKET_ALIGNMENT_WIDTH;
    // alignment units across the HI and LO halves together
    localparam int SHIFT_ALIGNED_WIDTH      = 2 * AXI_ALIGNED_WIDTH;

    // words per record, plus counter and slot index widths for assembly
    localparam int NUM_AXI        = (LOGGING_UNIT_WIDTH - 1) / AXI_WIDTH + 1;
    localparam int ASM_CNT_WIDTH  = 3;
    localparam int SLOT_IDX_WIDTH = 2;

    // trace length and replayed counters
    localparam int REPLAY_BITS_WIDTH = 32;
    localparam int AXI_CNT_WIDTH     = REPLAY_BITS_WIDTH - AXI_OFFSET_WIDTH;
    localparam int PKT_CNT_WIDTH     = REPLAY_BITS_WIDTH - PACKET_ALIGNMENT_WIDTH;

    typedef logic [AXI_WIDTH-1:0]                axi_word_t;
    typedef logic [LOGGING_UNIT_WIDTH-1:0]       unit_t;
    typedef logic [OFFSET_WIDTH-1:0]             bit_len_t;
    typedef logic [ALIGNED_OFFSET_WIDTH-1:0]     aligned_len_t;
    typedef logic [AXI_ALIGNED_OFFSET_WIDTH-1:0] aligned_off_t;
    typedef logic [REPLAY_BITS_WIDTH-1:0]        replay_cnt_t;

    // upper half of the shift buffer
    typedef enum logic [0:0] {
        HI_EMPTY,
        HI_FULL
    } hi_state_e;

    // lower half of the shift buffer
    typedef enum logic [1:0] {
        LO_EMPTY,
        LO_HEADER,
        LO_BODY
    } lo_state_e;

    // assembly buffer
    typedef enum logic [1:0] {
        ASM_WAIT_HEADER,
        ASM_WAIT_BODY,
        ASM_DONE
    } asm_state_e;

endpackage

// ==== design/hi_stage.sv ====
`timescale 1ns/1ns

module hi_stage (
    input  logic                           clk,
    input  logic                           sync_rst_n,
    input  replay_trace_pkg::axi_word_t    in_data,
    input  logic                           in_empty,
    input  logic                           out_almfull,
    input  logic                           hi_lo_shift,
    input  replay_trace_pkg::replay_cnt_t  replay_bits,
    output logic                           in_rd_en,
    output replay_trace_pkg::axi_word_t    hi_word,
    output logic                           hi_full
);
    import replay_trace_pkg::*;

    hi_state_e                hi_state;
    hi_state_e                hi_state_next;
    // any load into HI, real word or padding
    logic                     hi_load;
    // trailing all-zero word once the whole trace is in
    logic                     pad_last;
    replay_cnt_t              padded_bits;
    logic [AXI_CNT_WIDTH-1:0] word_total;
    logic [AXI_CNT_WIDTH-1:0] word_cnt;

    // room in HI when empty or when it moves down this cycle
    // almost-full from the output side throttles reads here
    assign in_rd_en = !in_empty && !out_almfull && (!hi_full || hi_lo_shift);

    // words needed to hold the trace, rounded up
    assign padded_bits = replay_bits + replay_cnt_t'(AXI_WIDTH - 1);
    assign word_total  = padded_bits[REPLAY_BITS_WIDTH-1:AXI_OFFSET_WIDTH];

    // padding only after something was read, and only once
    assign pad_last = (word_cnt != '0) && (word_cnt == word_total) &&
                      (!hi_full || hi_lo_shift);

    assign hi_load = in_rd_en || pad_last;
    assign hi_full = (hi_state == HI_FULL);

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= HI_EMPTY;
        end else begin
            hi_state <= hi_state_next;
        end
    end

    always_comb begin
        case (hi_state)
            HI_EMPTY: begin
                hi_state_next = hi_load ? HI_FULL : HI_EMPTY;
            end
            HI_FULL: begin
                // unload only when nothing refills it in the same cycle
                hi_state_next = (hi_lo_shift && !hi_load) ? HI_EMPTY : HI_FULL;
            end
            default: begin
                hi_state_next = HI_EMPTY;
            end
        endcase
    end

    // counts real and padding words alike
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            word_cnt <= '0;
        end else if (hi_load) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // fifo data has priority over the padding word
    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_word <= in_data;
        end else if (pad_last) begin
            hi_word <= '0;
        end
    end

endmodule

// ==== design/lo_stage.sv ====
`timescale 1ns/1ns

module lo_stage (
    input  logic                           clk,
    input  logic                           sync_rst_n,
    input  replay_trace_pkg::axi_word_t    hi_word,
    input  logic                           hi_full,
    input  replay_trace_pkg::replay_cnt_t  replay_bits,
    output logic                           hi_lo_shift,
    output logic                           asm_valid,
    output replay_trace_pkg::axi_word_t    asm_data,
    output replay_trace_pkg::bit_len_t     asm_len,
    output replay_trace_pkg::replay_cnt_t  rt_replay_bits
);
    import replay_trace_pkg::*;

    lo_state_e    lo_state;
    lo_state_e    lo_state_next;
    axi_word_t    lo_word;
    logic [SHIFT_ALIGNED_WIDTH-1:0][PACKET_ALIGNMENT-1:0] shift_bytes;
    axi_word_t    lo_out_data;
    aligned_off_t lo_valid_off;
    logic         lo_empty;
    logic         lo_out;
    aligned_len_t lo_remain_len;
    aligned_len_t lo_remain_len_reg;
    bit_len_t     off_sum;
    logic         lo_exhaust;
    logic         lo_satisfied;
    logic [PKT_CNT_WIDTH-1:0] pkt_total;
    logic [PKT_CNT_WIDTH-1:0] rt_pkt_cnt;
    logic [PKT_CNT_WIDTH-1:0] rt_pkt_next;
    aligned_len_t rt_pkt_add;
    logic         lo_replay_done;

    // HI on top of LO as a byte array
    assign shift_bytes = {hi_word, lo_word};
    // one word window starting at the valid offset inside LO
    assign lo_out_data = shift_bytes[lo_valid_off +: AXI_ALIGNED_WIDTH];

    assign lo_empty = (lo_state == LO_EMPTY);
    // window may straddle into HI so HI must hold data
    assign lo_out = hi_full && !lo_empty;
    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    // header decode in LO_HEADER and stored remainder in LO_BODY
    always_comb begin
        case (lo_state)
            LO_HEADER: begin
                lo_remain_len = lo_out_data[PACKET_ALIGNMENT_WIDTH +: ALIGNED_OFFSET_WIDTH];
            end
            LO_BODY: begin
                lo_remain_len = lo_remain_len_reg;
            end
            default: begin
                lo_remain_len = '0;
            end
        endcase
    end

    // widened sum so the offset plus a long remainder cannot wrap
    assign off_sum      = bit_len_t'(lo_remain_len) + bit_len_t'(lo_valid_off);
    // everything left in LO leaves this cycle
    assign lo_exhaust   = (off_sum >= bit_len_t'(AXI_ALIGNED_WIDTH));
    // current window finishes the unit
    assign lo_satisfied = (lo_remain_len <= aligned_len_t'(AXI_ALIGNED_WIDTH));

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= LO_EMPTY;
        end else begin
            lo_state <= lo_state_next;
        end
    end

    always_comb begin
        case (lo_state)
            LO_EMPTY: begin
                lo_state_next = hi_lo_shift ? LO_HEADER : LO_EMPTY;
            end
            LO_HEADER, LO_BODY: begin
                // unit ends here so the next window is a header
                // otherwise a full window went out and HI moved down
                if (lo_out) begin
                    lo_state_next = lo_satisfied ? LO_HEADER : LO_BODY;
                end else begin
                    lo_state_next = lo_state;
                end
            end
            default: begin
                lo_state_next = LO_EMPTY;
            end
        endcase
    end

    // offset advances only when a unit ends inside the window
    // low bits of the sum cover both the in-place and the shifted case
    // a full body window across a shift keeps the offset
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_valid_off <= '0;
        end else if (lo_out && lo_satisfied) begin
            lo_valid_off <= off_sum[AXI_ALIGNED_OFFSET_WIDTH-1:0];
        end
    end

    // remaining body after a full window is read back only in LO_BODY
    always_ff @(posedge clk) begin
        if (lo_out && !lo_satisfied) begin
            lo_remain_len_reg <= lo_remain_len - aligned_len_t'(AXI_ALIGNED_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi_word;
        end
    end

    // replayed count in alignment units
    assign pkt_total   = replay_bits[REPLAY_BITS_WIDTH-1:PACKET_ALIGNMENT_WIDTH];
    assign rt_pkt_next = rt_pkt_cnt + PKT_CNT_WIDTH'(rt_pkt_add);
    // the last counted window has already gone to assembly
    assign lo_replay_done = (pkt_total == rt_pkt_next);

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            rt_pkt_cnt <= '0;
            rt_pkt_add <= '0;
        end else begin
            rt_pkt_cnt <= rt_pkt_next;
            if (lo_out && !lo_replay_done) begin
                rt_pkt_add <= lo_satisfied ? lo_remain_len :
                                             aligned_len_t'(AXI_ALIGNED_WIDTH);
            end else begin
                rt_pkt_add <= '0;
            end
        end
    end

    assign rt_replay_bits = {rt_pkt_cnt, {PACKET_ALIGNMENT_WIDTH{1'b0}}};

    // register barrier in front of the assembler
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_valid <= 1'b0;
        end else begin
            asm_valid <= lo_out && !lo_replay_done;
        end
    end

    always_ff @(posedge clk) begin
        asm_data <= lo_out_data;
        // back to a bit length
        asm_len  <= {lo_remain_len, {PACKET_ALIGNMENT_WIDTH{1'b0}}};
    end

endmodule

// ==== design/unit_assembler.sv ====
`timescale 1ns/1ns

module unit_assembler (
    input  logic                         clk,
    input  logic                         sync_rst_n,
    input  logic                         asm_valid,
    input  replay_trace_pkg::axi_word_t  asm_data,
    input  replay_trace_pkg::bit_len_t   asm_len,
    output replay_trace_pkg::unit_t      out_data,
    output logic                         out_wr_en
);
    import replay_trace_pkg::*;

    asm_state_e asm_state;
    asm_state_e asm_state_next;
    logic [NUM_AXI-1:0][AXI_WIDTH-1:0] slots;
    logic [NUM_AXI*AXI_WIDTH-1:0]      slots_flat;
    // words stored for the current unit
    logic [ASM_CNT_WIDTH-1:0]          trace_axi_cnt;
    // unit length taken from its header word
    bit_len_t                          trace_len;
    // bits covered once the incoming word is stored
    logic [ASM_CNT_WIDTH+AXI_OFFSET_WIDTH-1:0] covered_bits;
    // header word already holds the whole unit
    logic                              head_fits;

    assign head_fits    = (asm_len <= bit_len_t'(AXI_WIDTH));
    assign covered_bits = {ASM_CNT_WIDTH'(trace_axi_cnt + 1'b1), {AXI_OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= ASM_WAIT_HEADER;
        end else begin
            asm_state <= asm_state_next;
        end
    end

    always_comb begin
        case (asm_state)
            ASM_WAIT_BODY: begin
                if (asm_valid && (trace_len <= covered_bits)) begin
                    asm_state_next = ASM_DONE;
                end else begin
                    asm_state_next = ASM_WAIT_BODY;
                end
            end
            ASM_WAIT_HEADER, ASM_DONE: begin
                // a header may arrive while the previous unit is written out
                if (asm_valid) begin
                    asm_state_next = head_fits ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HEADER;
                end
            end
            default: begin
                asm_state_next = ASM_WAIT_HEADER;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            trace_axi_cnt <= '0;
            trace_len     <= '0;
        end else if (asm_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                trace_axi_cnt <= trace_axi_cnt + 1'b1;
            end else begin
                // header word opens a new unit
                trace_len     <= asm_len;
                trace_axi_cnt <= ASM_CNT_WIDTH'(1);
            end
        end
    end

    // body words fill the next slot, a header always lands in slot 0
    always_ff @(posedge clk) begin
        if (asm_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                slots[trace_axi_cnt[SLOT_IDX_WIDTH-1:0]] <= asm_data;
            end else begin
                slots[0] <= asm_data;
            end
        end
    end

    // one write per completed unit, never stalled
    assign out_wr_en  = (asm_state == ASM_DONE);
    assign slots_flat = slots;
    assign out_data   = slots_flat[LOGGING_UNIT_WIDTH-1:0];

endmodule

// ==== design/replay_trace_parser.sv ====
`timescale 1ns/1ns

module replay_trace_parser (
    input  logic                           clk,
    input  logic                           sync_rst_n,
    input  replay_trace_pkg::axi_word_t    in_data,
    output logic                           in_rd_en,
    input  logic                           in_empty,
    input  logic                           out_almfull,
    output replay_trace_pkg::unit_t        out_data,
    output logic                           out_wr_en,
    input  replay_trace_pkg::replay_cnt_t  replay_bits,
    output replay_trace_pkg::replay_cnt_t  rt_replay_bits
);
    import replay_trace_pkg::*;

    // shift buffer between its halves
    axi_word_t hi_word;
    logic      hi_full;
    logic      hi_lo_shift;

    // registered windows into assembly
    logic      asm_valid;
    axi_word_t asm_data;
    bit_len_t  asm_len;

    // upper half, fed by the input fifo
    hi_stage u_hi_stage (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .hi_lo_shift (hi_lo_shift),
        .replay_bits (replay_bits),
        .in_rd_en    (in_rd_en),
        .hi_word     (hi_word),
        .hi_full     (hi_full)
    );

    // lower half, header decode and replayed count
    lo_stage u_lo_stage (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .hi_word        (hi_word),
        .hi_full        (hi_full),
        .replay_bits    (replay_bits),
        .hi_lo_shift    (hi_lo_shift),
        .asm_valid      (asm_valid),
        .asm_data       (asm_data),
        .asm_len        (asm_len),
        .rt_replay_bits (rt_replay_bits)
    );

    unit_assembler u_unit_assembler (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .asm_valid  (asm_valid),
        .asm_data   (asm_data),
        .asm_len    (asm_len),
        .out_data   (out_data),
        .out_wr_en  (out_wr_en)
    );

endmodule

// ==== testbench/replay_trace_checker.sv ====
`timescale 1ns/1ns

module replay_trace_checker (
    input  logic                           clk,
    input  logic                           sync_rst_n,
    input  logic                           in_rd_en,
    input  logic                           in_empty,
    input  logic                           out_almfull,
    input  logic                           out_wr_en,
    input  replay_trace_pkg::unit_t        out_data,
    input  replay_trace_pkg::replay_cnt_t  rt_replay_bits
);
    import replay_trace_pkg::*;

    // reads only from a non-empty fifo and with room downstream
    a_read_allowed: assert property (
        @(posedge clk) disable iff (!sync_rst_n)
        in_rd_en |-> (!in_empty && !out_almfull)
    ) else $error("input read while in_empty or out_almfull is high");

    // nothing can be assembled yet right after reset
    a_no_write_after_reset: assert property (
        @(posedge clk) $rose(sync_rst_n) |-> !out_wr_en
    ) else $error("out_wr_en high in the first cycle after reset");

    // header length of every written unit, 16 bits is the smallest unit
    a_unit_length: assert property (
        @(posedge clk) disable iff (!sync_rst_n)
        out_wr_en |-> (out_data[OFFSET_WIDTH-1:0] >= 16) &&
                      (out_data[OFFSET_WIDTH-1:0] <= LOGGING_UNIT_WIDTH)
    ) else $error("written unit has an out of range length field");

    a_replay_monotonic: assert property (
        @(posedge clk) disable iff (!sync_rst_n)
        $past(sync_rst_n) |-> (rt_replay_bits >= $past(rt_replay_bits))
    ) else $error("rt_replay_bits decreased");

    // count moves in whole bytes
    a_replay_aligned: assert property (
        @(posedge clk) disable iff (!sync_rst_n)
        rt_replay_bits[PACKET_ALIGNMENT_WIDTH-1:0] == '0
    ) else $error("rt_replay_bits not byte aligned");

endmodule

bind replay_trace_parser replay_trace_checker u_checker (
    .clk            (clk),
    .sync_rst_n     (sync_rst_n),
    .in_rd_en       (in_rd_en),
    .in_empty       (in_empty),
    .out_almfull    (out_almfull),
    .out_wr_en      (out_wr_en),
    .out_data       (out_data),
    .rt_replay_bits (rt_replay_bits)
);

// ==== testbench/tb_replay_trace_parser.sv ====
`timescale 1ns/1ns

module tb_replay_trace_parser;
    import replay_trace_pkg::*;

    localparam int HALF_PERIOD  = 20;
    localparam int PERIOD       = 2 * HALF_PERIOD;
    // outputs are read shortly before the rising edge
    localparam int SAMPLE_DELAY = HALF_PERIOD - 5;

    logic        clk = 1'b0;
    logic        sync_rst_n;
    axi_word_t   in_data;
    logic        in_rd_en;
    logic        in_empty;
    logic        out_almfull;
    unit_t       out_data;
    logic        out_wr_en;
    replay_cnt_t replay_bits;
    replay_cnt_t rt_replay_bits;

    // packed trace, the fifo contents and the expected units
    axi_word_t   trace_words[$];
    axi_word_t   fifo_q[$];
    unit_t       exp_units[$];
    bit_len_t    exp_lens[$];

    logic [31:0] gen_seed;
    logic [31:0] gap_seed;
    logic        empty_gaps;
    logic        almfull_gaps;
    logic        rd_seen;
    int          write_cnt;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    time         deadline;

    replay_trace_parser DUT (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .in_data        (in_data),
        .in_rd_en       (in_rd_en),
        .in_empty       (in_empty),
        .out_almfull    (out_almfull),
        .out_data       (out_data),
        .out_wr_en      (out_wr_en),
        .replay_bits    (replay_bits),
        .rt_replay_bits (rt_replay_bits)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte idx of the trace, little endian inside each word
    function automatic logic [7:0] stream_byte(input int idx);
        return trace_words[idx / 8][8 * (idx % 8) +: 8];
    endfunction

    function automatic unit_t len_mask(input bit_len_t len);
        unit_t m;
        m = '0;
        for (int i = 0; i < LOGGING_UNIT_WIDTH; i++) begin
            m[i] = (i < int'(len));
        end
        return m;
    endfunction

    // reference model: walk the packed stream header by header
    function automatic void build_expected();
        int       pos;
        int       total_bytes;
        bit_len_t len;
        unit_t    unit;
        exp_units = {};
        exp_lens  = {};
        pos = 0;
        total_bytes = int'(replay_bits) / 8;
        while (pos < total_bytes) begin
            len = stream_byte(pos);
            if (len == '0) begin
                break;
            end
            unit = '0;
            for (int i = 0; i < int'(len) / 8; i++) begin
                unit[8 * i +: 8] = stream_byte(pos + i);
            end
            exp_units.push_back(unit);
            exp_lens.push_back(len);
            pos += int'(len) / 8;
        end
    endfunction

    // random units packed back to back, zero fill in the last word
    task automatic build_stream(input int n_units, input int fixed_len);
        logic [7:0] bytes[$];
        axi_word_t  w;
        int         len;
        int         nbytes;
        bytes = {};
        trace_words = {};
        for (int u = 0; u < n_units; u++) begin
            if (fixed_len != 0) begin
                len = fixed_len;
            end else begin
                gen_seed = lcg_next(gen_seed);
                len = 8 * (2 + int'(gen_seed[31:16] % 16'd30));
            end
            bytes.push_back(8'(len));
            for (int i = 1; i < len / 8; i++) begin
                gen_seed = lcg_next(gen_seed);
                bytes.push_back(gen_seed[23:16]);
            end
        end
        nbytes = bytes.size();
        replay_bits = replay_cnt_t'(nbytes * 8);
        for (int b = 0; b < nbytes; b += 8) begin
            w = '0;
            for (int k = 0; k < 8; k++) begin
                if (b + k < nbytes) begin
                    w[8 * k +: 8] = bytes[b + k];
                end
            end
            trace_words.push_back(w);
        end
    endtask

    task automatic note_mismatch(input string sig_name, input unit_t expected,
                                 input unit_t actual);
        errors++;
        $display("Mismatch at %0t: %s expected %0h, got %0h",
                 $time, sig_name, expected, actual);
    endtask

    task automatic start_reset();
        @(negedge clk);
        sync_rst_n <= 1'b0;
    endtask

    task automatic release_reset();
        repeat (2) @(negedge clk);
        sync_rst_n <= 1'b1;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %-28s %s", name, (errors == err_before) ? "pass" : "FAIL");
    endtask

    // no input at all, so nothing may come out
    task automatic idle_check();
        int err_before;
        err_before = errors;
        start_reset();
        replay_bits = '0;
        release_reset();
        repeat (8) begin
            @(negedge clk);
            checks += 2;
            if (out_wr_en !== 1'b0) begin
                note_mismatch("out_wr_en", '0, unit_t'(out_wr_en));
            end
            if (rt_replay_bits !== '0) begin
                note_mismatch("rt_replay_bits", '0, unit_t'(rt_replay_bits));
            end
        end
        finish_test("idle after reset", err_before);
    endtask

    task automatic run_stream(input string name, input int n_units, input int fixed_len,
                              input logic use_empty_gaps, input logic use_almfull_gaps);
        int err_before;
        int n_exp;
        int cycles;
        err_before = errors;
        start_reset();
        build_stream(n_units, fixed_len);
        build_expected();
        n_exp = exp_units.size();
        write_cnt = 0;
        release_reset();
        // load away from the falling edge where the fifo model runs
        @(posedge clk);
        empty_gaps   = use_empty_gaps;
        almfull_gaps = use_almfull_gaps;
        fifo_q       = trace_words;
        cycles       = 40 * trace_words.size() + 200;
        deadline     = $time + cycles * PERIOD;
        while (write_cnt < n_exp) begin
            @(negedge clk);
        end
        // let the padding word drain, it must add nothing
        repeat (20) @(negedge clk);
        deadline = 0;
        checks += 2;
        if (write_cnt != n_exp) begin
            note_mismatch("write count", unit_t'(n_exp), unit_t'(write_cnt));
        end
        if (rt_replay_bits != replay_bits) begin
            note_mismatch("rt_replay_bits", unit_t'(replay_bits), unit_t'(rt_replay_bits));
        end
        finish_test(name, err_before);
    endtask

    // show-ahead fifo model plus random empty and almost-full gaps
    initial begin
        in_data     = '0;
        in_empty    = 1'b1;
        out_almfull = 1'b0;
        rd_seen     = 1'b0;
        gap_seed    = lcg_next(32'h4fa6_9b07);
        forever begin
            @(negedge clk);
            // a read at the last edge consumed the head word
            if (rd_seen && fifo_q.size() > 0) begin
                void'(fifo_q.pop_front());
            end
            gap_seed    = lcg_next(gap_seed);
            in_empty    = (fifo_q.size() == 0) || (empty_gaps && gap_seed[31:30] == 2'b00);
            out_almfull = almfull_gaps && (gap_seed[29:28] == 2'b00);
            in_data     = (fifo_q.size() > 0) ? fifo_q[0] : '0;
            #SAMPLE_DELAY;
            rd_seen = in_rd_en;
            if (out_almfull) begin
                checks++;
                if (in_rd_en) begin
                    errors++;
                    $display("input word read at %0t while out_almfull was high", $time);
                end
            end
        end
    end

    // compare each written unit with the head of the expected list
    always @(negedge clk) begin
        unit_t    exp_unit;
        bit_len_t exp_len;
        unit_t    mask;
        if (out_wr_en) begin
            write_cnt++;
            if (exp_units.size() == 0) begin
                errors++;
                $display("unit written at %0t with no unit expected", $time);
            end else begin
                exp_unit = exp_units.pop_front();
                exp_len  = exp_lens.pop_front();
                // bits above the length belong to the next unit
                mask = len_mask(exp_len);
                checks += 2;
                if (out_data[OFFSET_WIDTH-1:0] != exp_len) begin
                    note_mismatch("out_data length", unit_t'(exp_len),
                                  unit_t'(out_data[OFFSET_WIDTH-1:0]));
                end
                if ((out_data & mask) != (exp_unit & mask)) begin
                    note_mismatch("out_data", exp_unit & mask, out_data & mask);
                end
            end
        end
    end

    // per test limit, armed while a stream runs
    always @(negedge clk) begin
        if (deadline != 0 && $time > deadline) begin
            $display("timeout at %0t, the parser stopped writing units", $time);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        sync_rst_n   = 1'b0;
        replay_bits  = '0;
        empty_gaps   = 1'b0;
        almfull_gaps = 1'b0;
        gen_seed     = 32'h4fa6_9b07;
        write_cnt    = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        deadline     = 0;

        idle_check();
        run_stream("single short unit", 1, 48, 1'b0, 1'b0);
        run_stream("straddling units", 12, 0, 1'b0, 1'b0);
        run_stream("in_empty gaps", 12, 0, 1'b1, 1'b0);
        run_stream("out_almfull gaps", 12, 0, 1'b0, 1'b1);
        run_stream("long trace, all gaps", 24, 0, 1'b1, 1'b1);

        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== replay_trace_parser.f ====
design/replay_trace_pkg.sv
design/hi_stage.sv
design/lo_stage.sv
design/unit_assembler.sv
design/replay_trace_parser.sv
testbench/replay_trace_checker.sv
testbench/tb_replay_trace_parser.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_replay_trace_parser
FILELIST  = replay_trace_parser.f
LOG       = sim.log
FAIL_MSG  = Checks failed
PASS_MSG  = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
